//--- logic/mxu_array.sv
`timescale 1ns/1ps
`default_nettype none

module mxu_array (
    input  wire logic                clk,
    input  wire logic                rst_n,
    input  wire mxu_cfg_pkg::elem_t  col_weight [mxu_cfg_pkg::ARRAY_DIM],
    input  wire logic                weight_shift,
    input  wire mxu_cfg_pkg::elem_t  row_x [mxu_cfg_pkg::ARRAY_DIM],
    input  wire logic [mxu_cfg_pkg::ARRAY_DIM-1:0] row_x_valid,
    output mxu_cfg_pkg::elem_t       col_sum [mxu_cfg_pkg::ARRAY_DIM],
    output logic [mxu_cfg_pkg::ARRAY_DIM-1:0] col_sum_valid
);

    localparam int N = mxu_cfg_pkg::ARRAY_DIM;

    // Grid nets, one extra entry along the direction of travel
    mxu_cfg_pkg::elem_t w_net    [N+1][N];
    mxu_cfg_pkg::elem_t psum_net [N+1][N];
    mxu_cfg_pkg::elem_t x_net    [N][N+1];
    logic               xv_net   [N][N+1];
    logic               pv_net   [N][N];

    for (genvar k = 0; k < N; k++) begin : g_row
        assign x_net[k][0]  = row_x[k];
        assign xv_net[k][0] = row_x_valid[k];

        for (genvar c = 0; c < N; c++) begin : g_col
            mxu_pe u_pe (
                .clk           (clk),
                .rst_n         (rst_n),
                .w_in          (w_net[k][c]),
                .w_shift       (weight_shift),
                .x_in          (x_net[k][c]),
                .x_valid_in    (xv_net[k][c]),
                .psum_in       (psum_net[k][c]),
                .w_out         (w_net[k+1][c]),
                .x_out         (x_net[k][c+1]),
                .x_valid_out   (xv_net[k][c+1]),
                .psum_out      (psum_net[k+1][c]),
                .psum_valid_out(pv_net[k][c])
            );
        end
    end

    // Top edge takes weights and a zero sum, bottom edge gives results
    for (genvar c = 0; c < N; c++) begin : g_edge
        assign w_net[0][c]    = col_weight[c];
        assign psum_net[0][c] = '0;
        assign col_sum[c]       = psum_net[N][c];
        assign col_sum_valid[c] = pv_net[N-1][c];
    end

endmodule

`default_nettype wire

//--- logic/mxu_cfg_pkg.sv
`default_nettype none

package mxu_cfg_pkg;

    //////////////////////////////////////////////////
    // Array geometry
    //////////////////////////////////////////////////

    // Side of the PE grid and of both operand matrices
    localparam int ARRAY_DIM  = 4;
    localparam int ELEM_W     = 32;
    localparam int ELEM_COUNT = ARRAY_DIM * ARRAY_DIM;

    //////////////////////////////////////////////////
    // Datapath types
    //////////////////////////////////////////////////

    // Matrix element and partial sum, wraps modulo 2^32
    typedef logic signed [ELEM_W-1:0] elem_t;

    // Row-major element index, row*ARRAY_DIM + col
    typedef logic [$clog2(ELEM_COUNT)-1:0] elem_idx_t;
    typedef logic [$clog2(ARRAY_DIM)-1:0] dim_idx_t;

endpackage

`default_nettype wire

//--- logic/mxu_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module mxu_ctrl (
    input  wire logic                   clk,
    input  wire logic                   rst_n,
    input  wire logic                   start,
    input  wire mxu_mem_pkg::addr_t     base_addr_w,
    input  wire mxu_mem_pkg::addr_t     base_addr_x,
    input  wire mxu_mem_pkg::addr_t     base_addr_out,
    input  wire mxu_cfg_pkg::elem_t     mem_resp_data,
    input  wire logic                   run_done,
    input  wire logic                   full,
    input  wire mxu_cfg_pkg::elem_t     rd_data,
    output logic                        done,
    output mxu_mem_pkg::addr_t          mem_req_addr,
    output mxu_cfg_pkg::elem_t          mem_req_data,
    output logic                        mem_read_en,
    output logic                        mem_write_en,
    output logic                        load_we,
    output logic                        load_sel_x,
    output mxu_cfg_pkg::elem_idx_t      load_idx,
    output mxu_cfg_pkg::elem_t          load_data,
    output logic                        run_start,
    output logic                        clear,
    output mxu_cfg_pkg::elem_idx_t      rd_idx
);

    mxu_mem_pkg::ctrl_state_t state;
    mxu_mem_pkg::addr_t       base_w_q, base_x_q, base_out_q;
    mxu_mem_pkg::lat_cnt_t    lat;
    mxu_cfg_pkg::elem_idx_t   idx;
    logic                     beat_end;
    logic                     last_elem;

    assign beat_end  = (lat == mxu_mem_pkg::lat_cnt_t'(mxu_mem_pkg::MEM_LATENCY - 1));
    assign last_elem = (idx == mxu_cfg_pkg::elem_idx_t'(mxu_cfg_pkg::ELEM_COUNT - 1));
    assign rd_idx    = idx;

    //////////////////////////////////////////////////
    // Sequencer
    //////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state        <= mxu_mem_pkg::IDLE;
            idx          <= '0;
            lat          <= '0;
            done         <= 1'b0;
            mem_read_en  <= 1'b0;
            mem_write_en <= 1'b0;
            load_we      <= 1'b0;
            run_start    <= 1'b0;
            clear        <= 1'b0;
        end else begin
            done         <= 1'b0;
            mem_read_en  <= 1'b0;
            mem_write_en <= 1'b0;
            load_we      <= 1'b0;
            run_start    <= 1'b0;
            clear        <= 1'b0;
            lat          <= beat_end ? lat : lat + 2'd1;
            case (state)
                mxu_mem_pkg::IDLE: begin
                    if (start) begin
                        clear <= 1'b1;
                        idx   <= '0;
                        state <= mxu_mem_pkg::LOAD_W_REQ;
                    end
                end
                mxu_mem_pkg::LOAD_W_REQ, mxu_mem_pkg::LOAD_X_REQ: begin
                    mem_read_en <= 1'b1;
                    lat         <= '0;
                    state       <= (state == mxu_mem_pkg::LOAD_W_REQ) ?
                                   mxu_mem_pkg::LOAD_W_WAIT : mxu_mem_pkg::LOAD_X_WAIT;
                end
                mxu_mem_pkg::LOAD_W_WAIT, mxu_mem_pkg::LOAD_X_WAIT: begin
                    if (beat_end) begin
                        load_we <= 1'b1;
                        idx     <= idx + 1'b1;
                        if (!last_elem) begin
                            state <= (state == mxu_mem_pkg::LOAD_W_WAIT) ?
                                     mxu_mem_pkg::LOAD_W_REQ : mxu_mem_pkg::LOAD_X_REQ;
                        end else if (state == mxu_mem_pkg::LOAD_W_WAIT) begin
                            state <= mxu_mem_pkg::LOAD_X_REQ;
                        end else begin
                            run_start <= 1'b1;
                            state     <= mxu_mem_pkg::RUN;
                        end
                    end
                end
                mxu_mem_pkg::RUN: begin
                    if (run_done) state <= mxu_mem_pkg::DRAIN;
                end
                // Last sums are still in the bottom rows when the feeder ends
                mxu_mem_pkg::DRAIN: begin
                    if (full) state <= mxu_mem_pkg::STORE_REQ;
                end
                mxu_mem_pkg::STORE_REQ: begin
                    mem_write_en <= 1'b1;
                    lat          <= '0;
                    state        <= mxu_mem_pkg::STORE_WAIT;
                end
                mxu_mem_pkg::STORE_WAIT: begin
                    if (beat_end) begin
                        idx   <= idx + 1'b1;
                        state <= last_elem ? mxu_mem_pkg::DONE : mxu_mem_pkg::STORE_REQ;
                    end
                end
                mxu_mem_pkg::DONE: begin
                    done  <= 1'b1;
                    state <= mxu_mem_pkg::IDLE;
                end
                default: state <= mxu_mem_pkg::IDLE;
            endcase
        end
    end

    // Addresses and data, qualified by the strobes above
    always_ff @(posedge clk) begin
        if (state == mxu_mem_pkg::IDLE && start) begin
            base_w_q   <= base_addr_w;
            base_x_q   <= base_addr_x;
            base_out_q <= base_addr_out;
        end
        case (state)
            mxu_mem_pkg::LOAD_W_REQ: mem_req_addr <= base_w_q + mxu_mem_pkg::addr_t'(idx);
            mxu_mem_pkg::LOAD_X_REQ: mem_req_addr <= base_x_q + mxu_mem_pkg::addr_t'(idx);
            mxu_mem_pkg::STORE_REQ: begin
                mem_req_addr <= base_out_q + mxu_mem_pkg::addr_t'(idx);
                mem_req_data <= rd_data;
            end
            default: ;
        endcase
        load_sel_x <= (state == mxu_mem_pkg::LOAD_X_WAIT);
        load_idx   <= idx;
        load_data  <= mem_resp_data;
    end

endmodule

`default_nettype wire

//--- logic/mxu_feeder.sv
`timescale 1ns/1ps
`default_nettype none

module mxu_feeder (
    input  wire logic                   clk,
    input  wire logic                   rst_n,
    input  wire logic                   load_we,
    input  wire logic                   load_sel_x,
    input  wire mxu_cfg_pkg::elem_idx_t load_idx,
    input  wire mxu_cfg_pkg::elem_t     load_data,
    input  wire logic                   run_start,
    output logic                        run_done,
    output mxu_cfg_pkg::elem_t          col_weight [mxu_cfg_pkg::ARRAY_DIM],
    output logic                        weight_shift,
    output mxu_cfg_pkg::elem_t          row_x [mxu_cfg_pkg::ARRAY_DIM],
    output logic [mxu_cfg_pkg::ARRAY_DIM-1:0] row_x_valid
);

    localparam int N = mxu_cfg_pkg::ARRAY_DIM;

    mxu_cfg_pkg::elem_t w_buf [mxu_cfg_pkg::ELEM_COUNT];
    mxu_cfg_pkg::elem_t x_buf [mxu_cfg_pkg::ELEM_COUNT];

    logic       active;
    logic [3:0] phase;

    always_ff @(posedge clk) begin
        if (load_we && load_sel_x) begin
            x_buf[load_idx] <= load_data;
        end
        if (load_we && !load_sel_x) begin
            w_buf[load_idx] <= load_data;
        end
    end

    // Fixed schedule of 3*N+2 cycles
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            active   <= 1'b0;
            phase    <= '0;
            run_done <= 1'b0;
        end else begin
            run_done <= 1'b0;
            if (run_start) begin
                active <= 1'b1;
                phase  <= '0;
            end else if (active) begin
                if (phase == 4'(3 * N + 1)) begin
                    active   <= 1'b0;
                    run_done <= 1'b1;
                end
                phase <= phase + 4'd1;
            end
        end
    end

    //////////////////////////////////////////////////
    // Operand schedule
    //////////////////////////////////////////////////

    // Weights go in bottom row first, X row r meets array row k at 4+r+k
    always_comb begin
        int r;
        weight_shift = active && (phase < 4'(N));
        for (int k = 0; k < N; k++) begin
            col_weight[k]  = weight_shift ? w_buf[(N - 1 - int'(phase)) * N + k] : '0;
            r              = int'(phase) - N - k;
            row_x_valid[k] = active && (r >= 0) && (r < N);
            row_x[k]       = row_x_valid[k] ? x_buf[r * N + k] : '0;
        end
    end

endmodule

`default_nettype wire

//--- logic/mxu_mem_pkg.sv
`default_nettype none

package mxu_mem_pkg;

    // Word address into the shared memory
    localparam int ADDR_W = 13;

    // Cycles from request to the beat where read data is sampled
    localparam int MEM_LATENCY = 3;

    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [1:0] lat_cnt_t;

    // Run sequencer states
    typedef enum logic [3:0] {
        IDLE,
        LOAD_W_REQ,
        LOAD_W_WAIT,
        LOAD_X_REQ,
        LOAD_X_WAIT,
        RUN,
        DRAIN,
        STORE_REQ,
        STORE_WAIT,
        DONE
    } ctrl_state_t;

endpackage

`default_nettype wire

//--- logic/mxu_pe.sv
`timescale 1ns/1ps
`default_nettype none

module mxu_pe (
    input  wire logic                clk,
    input  wire logic                rst_n,
    input  wire mxu_cfg_pkg::elem_t  w_in,
    input  wire logic                w_shift,
    input  wire mxu_cfg_pkg::elem_t  x_in,
    input  wire logic                x_valid_in,
    input  wire mxu_cfg_pkg::elem_t  psum_in,
    output mxu_cfg_pkg::elem_t       w_out,
    output mxu_cfg_pkg::elem_t       x_out,
    output logic                     x_valid_out,
    output mxu_cfg_pkg::elem_t       psum_out,
    output logic                     psum_valid_out
);

    // Stationary weight, also the next stage of the weight shift chain
    mxu_cfg_pkg::elem_t weight;

    assign w_out = weight;

    always_ff @(posedge clk) begin
        if (w_shift) begin
            weight <= w_in;
        end
        if (x_valid_in) begin
            x_out    <= x_in;
            psum_out <= psum_in + x_in * weight;  // truncates, wraps
        end
    end

    // Valid travels right with X and down with the sum
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            x_valid_out    <= 1'b0;
            psum_valid_out <= 1'b0;
        end else begin
            x_valid_out    <= x_valid_in;
            psum_valid_out <= x_valid_in;
        end
    end

endmodule

`default_nettype wire

//--- logic/mxu_result_collect.sv
`timescale 1ns/1ps
`default_nettype none

module mxu_result_collect (
    input  wire logic                   clk,
    input  wire logic                   rst_n,
    input  wire logic                   clear,
    input  wire mxu_cfg_pkg::elem_t     col_sum [mxu_cfg_pkg::ARRAY_DIM],
    input  wire logic [mxu_cfg_pkg::ARRAY_DIM-1:0] col_sum_valid,
    input  wire mxu_cfg_pkg::elem_idx_t rd_idx,
    output mxu_cfg_pkg::elem_t          rd_data,
    output logic                        full
);

    localparam int N = mxu_cfg_pkg::ARRAY_DIM;

    mxu_cfg_pkg::elem_t res_buf [mxu_cfg_pkg::ELEM_COUNT];

    // Next row to fill in each column, bit 2 set once the column is complete
    logic [2:0]   row_ptr [N];
    logic [N-1:0] take;
    logic [N-1:0] col_full;

    for (genvar c = 0; c < N; c++) begin : g_col
        assign col_full[c] = row_ptr[c][2];
        assign take[c]     = col_sum_valid[c] && !col_full[c];
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int c = 0; c < N; c++) begin
                row_ptr[c] <= '0;
            end
        end else begin
            for (int c = 0; c < N; c++) begin
                if (clear) begin
                    row_ptr[c] <= '0;
                end else if (take[c]) begin
                    row_ptr[c] <= row_ptr[c] + 3'd1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int c = 0; c < N; c++) begin
            if (take[c]) begin
                res_buf[{row_ptr[c][1:0], mxu_cfg_pkg::dim_idx_t'(c)}] <= col_sum[c];
            end
        end
    end

    assign full    = &col_full;
    assign rd_data = res_buf[rd_idx];

endmodule

`default_nettype wire

//--- logic/mxu_top.sv
`timescale 1ns/1ps
`default_nettype none

module mxu_top (
    input  wire logic               clk,
    input  wire logic               rst_n,
    input  wire logic               start,
    output logic                    done,
    input  wire mxu_mem_pkg::addr_t base_addr_w,
    input  wire mxu_mem_pkg::addr_t base_addr_x,
    input  wire mxu_mem_pkg::addr_t base_addr_out,
    output mxu_mem_pkg::addr_t      mem_req_addr,
    output mxu_cfg_pkg::elem_t      mem_req_data,
    input  wire mxu_cfg_pkg::elem_t mem_resp_data,
    output logic                    mem_read_en,
    output logic                    mem_write_en
);

    localparam int N = mxu_cfg_pkg::ARRAY_DIM;

    logic                   load_we, load_sel_x, run_start, run_done, clear, full;
    mxu_cfg_pkg::elem_idx_t load_idx, rd_idx;
    mxu_cfg_pkg::elem_t     load_data, rd_data;
    logic                   weight_shift;
    mxu_cfg_pkg::elem_t     col_weight [N];
    mxu_cfg_pkg::elem_t     row_x [N];
    logic [N-1:0]           row_x_valid;
    mxu_cfg_pkg::elem_t     col_sum [N];
    logic [N-1:0]           col_sum_valid;

    mxu_ctrl u_ctrl (
        .clk(clk), .rst_n(rst_n), .start(start), .done(done),
        .base_addr_w(base_addr_w), .base_addr_x(base_addr_x),
        .base_addr_out(base_addr_out), .mem_resp_data(mem_resp_data),
        .mem_req_addr(mem_req_addr), .mem_req_data(mem_req_data),
        .mem_read_en(mem_read_en), .mem_write_en(mem_write_en),
        .run_done(run_done), .full(full), .rd_data(rd_data),
        .load_we(load_we), .load_sel_x(load_sel_x), .load_idx(load_idx),
        .load_data(load_data), .run_start(run_start), .clear(clear), .rd_idx(rd_idx)
    );

    mxu_feeder u_feeder (
        .clk(clk), .rst_n(rst_n), .load_we(load_we), .load_sel_x(load_sel_x),
        .load_idx(load_idx), .load_data(load_data), .run_start(run_start),
        .run_done(run_done), .col_weight(col_weight), .weight_shift(weight_shift),
        .row_x(row_x), .row_x_valid(row_x_valid)
    );

    mxu_array u_array (
        .clk(clk), .rst_n(rst_n), .col_weight(col_weight), .weight_shift(weight_shift),
        .row_x(row_x), .row_x_valid(row_x_valid),
        .col_sum(col_sum), .col_sum_valid(col_sum_valid)
    );

    mxu_result_collect u_collect (
        .clk(clk), .rst_n(rst_n), .clear(clear), .col_sum(col_sum),
        .col_sum_valid(col_sum_valid), .rd_idx(rd_idx), .rd_data(rd_data), .full(full)
    );

endmodule

`default_nettype wire

//--- run.sh
#!/bin/sh
# Build the MXU testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal --top-module tb_mxu -f sources.f -o tb_mxu_sim &&
out="$(./obj_dir/tb_mxu_sim)" ;
echo "$out" ;
echo "$out" | grep -qxF '>>> PASS' || exit 1

//--- sim/mxu_props.sv
`timescale 1ns/1ps
`default_nettype none

module mxu_props (
    input wire logic                      clk,
    input wire logic                      rst_n,
    input wire logic                      done,
    input wire logic                      mem_read_en,
    input wire logic                      mem_write_en,
    input wire mxu_mem_pkg::ctrl_state_t  state
);

    int fail_count = 0;

    a_rw_exclusive: assert property (@(posedge clk) disable iff (!rst_n)
        !(mem_read_en && mem_write_en))
        else begin
            fail_count++;
            $error("memory read and write strobes high in the same cycle");
        end

    a_done_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        done |=> !done)
        else begin
            fail_count++;
            $error("done held high for more than one cycle");
        end

    // Write strobe only comes out of the store beat
    a_write_in_store: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(mem_write_en) |->
            (state == mxu_mem_pkg::STORE_REQ || state == mxu_mem_pkg::STORE_WAIT))
        else begin
            fail_count++;
            $error("write strobe rose outside the store states");
        end

endmodule

bind mxu_ctrl mxu_props u_props (
    .clk         (clk),
    .rst_n       (rst_n),
    .done        (done),
    .mem_read_en (mem_read_en),
    .mem_write_en(mem_write_en),
    .state       (state)
);

`default_nettype wire

//--- sim/tb_clk_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen (
    output logic clk,
    output logic rst_n
);

    localparam int RESET_CYCLES = 16;

    // 4 ns period
    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // Release a little after the edge so the DUT never sees it mid-edge
    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #1 rst_n = 1'b1;
    end

endmodule

`default_nettype wire

//--- sim/tb_mxu.sv
`timescale 1ns/1ps
`default_nettype none

module tb_mxu;

    localparam int SEED          = 32'h7797_d69f;
    localparam int TEST_COUNT    = 6;
    localparam int RESET_TIMEOUT = 100;
    localparam int RUN_TIMEOUT   = 1000;
    localparam int D             = mxu_cfg_pkg::ARRAY_DIM;
    localparam int E             = mxu_cfg_pkg::ELEM_COUNT;

    logic               clk, rst_n, start, done, mem_read_en, mem_write_en;
    mxu_mem_pkg::addr_t base_addr_w, base_addr_x, base_addr_out, mem_req_addr;
    mxu_cfg_pkg::elem_t mem_req_data;
    mxu_cfg_pkg::elem_t mem_resp_data = '0;

    // Preload path into the memory model
    logic               pre_we;
    mxu_mem_pkg::addr_t pre_addr;
    mxu_cfg_pkg::elem_t pre_data;
    mxu_cfg_pkg::elem_t mem [2**mxu_mem_pkg::ADDR_W];

    // Read request waiting out the latency
    logic               rd_pend = 1'b0;
    mxu_mem_pkg::addr_t rd_addr = '0;

    logic               test_open, quiet;
    logic [127:0]       test_name;
    mxu_mem_pkg::addr_t exp_base;
    mxu_cfg_pkg::elem_t w_mat [E];
    mxu_cfg_pkg::elem_t x_mat [E];
    mxu_cfg_pkg::elem_t w_b [E];
    mxu_cfg_pkg::elem_t x_b [E];
    int                 tests_passed, tests_failed, err_total;

    tb_clk_gen u_clk_gen (.clk(clk), .rst_n(rst_n));

    mxu_top u_dut (
        .clk          (clk),
        .rst_n        (rst_n),
        .start        (start),
        .done         (done),
        .base_addr_w  (base_addr_w),
        .base_addr_x  (base_addr_x),
        .base_addr_out(base_addr_out),
        .mem_req_addr (mem_req_addr),
        .mem_req_data (mem_req_data),
        .mem_resp_data(mem_resp_data),
        .mem_read_en  (mem_read_en),
        .mem_write_en (mem_write_en)
    );

    tb_mxu_checker u_checker (
        .clk(clk), .rst_n(rst_n), .done(done),
        .mem_read_en(mem_read_en), .mem_write_en(mem_write_en),
        .mem_req_addr(mem_req_addr), .mem_req_data(mem_req_data),
        .test_open(test_open), .quiet(quiet), .test_name(test_name),
        .exp_base(exp_base), .w_mat(w_mat), .x_mat(x_mat),
        .tests_passed(tests_passed), .tests_failed(tests_failed), .err_total(err_total)
    );

    // Read data shows up in cycle C+MEM_LATENCY-1, the last one the protocol allows
    always @(posedge clk) begin
        if (pre_we) begin
            mem[pre_addr] <= pre_data;
        end
        if (mem_write_en) begin
            mem[mem_req_addr] <= mem_req_data;
        end
        rd_pend <= mem_read_en;
        rd_addr <= mem_req_addr;
        if (rd_pend) begin
            mem_resp_data <= mem[rd_addr];
        end
    end

    function automatic mxu_cfg_pkg::elem_t rand_small();
        return mxu_cfg_pkg::elem_t'($urandom_range(2000, 0)) - 32'sd1000;
    endfunction

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display(">>> FAIL");
        $finish;
    endtask

    task automatic put_word(input mxu_mem_pkg::addr_t addr, input mxu_cfg_pkg::elem_t data);
        pre_we   = 1'b1;
        pre_addr = addr;
        pre_data = data;
        @(posedge clk);
        #1 pre_we = 1'b0;
    endtask

    task automatic load_operands(
        input mxu_cfg_pkg::elem_t w [E],
        input mxu_cfg_pkg::elem_t x [E],
        input mxu_mem_pkg::addr_t bw,
        input mxu_mem_pkg::addr_t bx
    );
        for (int i = 0; i < E; i++) begin
            put_word(bw + mxu_mem_pkg::addr_t'(i), w[i]);
            put_word(bx + mxu_mem_pkg::addr_t'(i), x[i]);
        end
    endtask

    //////////////////////////////////////////////////
    // Test steps
    //////////////////////////////////////////////////

    task automatic check_reset_quiet();
        int cyc;
        test_name = "reset_quiet";
        quiet     = 1'b1;
        test_open = 1'b1;
        for (cyc = 0; cyc < RESET_TIMEOUT && !rst_n; cyc++) begin
            @(posedge clk);
        end
        if (!rst_n) abort_run("reset was never released");
        repeat (20) @(posedge clk);
        #1 test_open = 1'b0;
        @(posedge clk);
        #1 quiet = 1'b0;
    endtask

    // Extra start requests carry other bases and must be ignored while busy
    task automatic run_matrix(
        input logic [127:0]       name,
        input mxu_mem_pkg::addr_t bw,
        input mxu_mem_pkg::addr_t bx,
        input mxu_mem_pkg::addr_t bo,
        input bit                 extra
    );
        int cyc;
        bit seen;
        test_name     = name;
        exp_base      = bo;
        test_open     = 1'b1;
        base_addr_w   = bw;
        base_addr_x   = bx;
        base_addr_out = bo;
        start         = 1'b1;
        seen          = 1'b0;
        for (cyc = 0; cyc < RUN_TIMEOUT && !seen; cyc++) begin
            @(posedge clk);
            #1 start = 1'b0;
            seen = done;
            if (extra && !seen && (cyc == 40 || cyc == 160)) begin
                base_addr_w   = bo;
                base_addr_x   = bw;
                base_addr_out = bx;
                start         = 1'b1;
            end
        end
        start = 1'b0;
        if (!seen) abort_run("timed out waiting for done");
        repeat (3) @(posedge clk);
        #1 test_open = 1'b0;
        @(posedge clk);
        #1;
    endtask

    initial begin
        int seed_ret;
        seed_ret      = $urandom(SEED);
        start         = 1'b0;
        base_addr_w   = '0;
        base_addr_x   = '0;
        base_addr_out = '0;
        pre_we        = 1'b0;
        pre_addr      = '0;
        pre_data      = '0;
        test_open     = 1'b0;
        quiet         = 1'b1;
        test_name     = '0;
        exp_base      = '0;
        for (int i = 0; i < E; i++) begin
            w_mat[i] = '0;
            x_mat[i] = '0;
        end
        check_reset_quiet();

        for (int i = 0; i < E; i++) begin
            w_mat[i] = (i / D == i % D) ? 32'sd1 : 32'sd0;
            x_mat[i] = rand_small();
        end
        load_operands(w_mat, x_mat, 13'h0100, 13'h0200);
        run_matrix("identity_w", 13'h0100, 13'h0200, 13'h0300, 1'b0);

        for (int i = 0; i < E; i++) begin
            w_mat[i] = rand_small();
            x_mat[i] = rand_small();
        end
        load_operands(w_mat, x_mat, 13'h0400, 13'h0500);
        run_matrix("random_product", 13'h0400, 13'h0500, 13'h0600, 1'b0);

        // Full-range values plus the most negative and most positive words
        for (int i = 0; i < E; i++) begin
            w_mat[i] = mxu_cfg_pkg::elem_t'($urandom());
            x_mat[i] = mxu_cfg_pkg::elem_t'($urandom());
        end
        w_mat[0] = 32'h8000_0000;
        x_mat[0] = 32'h8000_0000;
        x_mat[1] = 32'h7fff_ffff;
        load_operands(w_mat, x_mat, 13'h0700, 13'h0800);
        run_matrix("wraparound", 13'h0700, 13'h0800, 13'h0900, 1'b0);

        // Both runs preloaded so the second start follows the first done closely
        for (int i = 0; i < E; i++) begin
            w_mat[i] = rand_small();
            x_mat[i] = rand_small();
            w_b[i]   = rand_small();
            x_b[i]   = rand_small();
        end
        load_operands(w_mat, x_mat, 13'h1000, 13'h1100);
        load_operands(w_b, x_b, 13'h1200, 13'h1300);
        run_matrix("back_to_back_a", 13'h1000, 13'h1100, 13'h1400, 1'b1);
        w_mat = w_b;
        x_mat = x_b;
        run_matrix("back_to_back_b", 13'h1200, 13'h1300, 13'h1500, 1'b1);

        $display("%0d tests run, %0d passed, %0d failed, %0d errors, %0d assertion failures",
                 TEST_COUNT, tests_passed, tests_failed, err_total,
                 u_dut.u_ctrl.u_props.fail_count);
        if (tests_failed == 0 && err_total == 0 && tests_passed == TEST_COUNT &&
            u_dut.u_ctrl.u_props.fail_count == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- sim/tb_mxu_checker.sv
`timescale 1ns/1ps
`default_nettype none

module tb_mxu_checker (
    input  wire logic                clk,
    input  wire logic                rst_n,
    input  wire logic                done,
    input  wire logic                mem_read_en,
    input  wire logic                mem_write_en,
    input  wire mxu_mem_pkg::addr_t  mem_req_addr,
    input  wire mxu_cfg_pkg::elem_t  mem_req_data,
    input  wire logic                test_open,
    input  wire logic                quiet,
    input  wire logic [127:0]        test_name,
    input  wire mxu_mem_pkg::addr_t  exp_base,
    input  wire mxu_cfg_pkg::elem_t  w_mat [mxu_cfg_pkg::ELEM_COUNT],
    input  wire mxu_cfg_pkg::elem_t  x_mat [mxu_cfg_pkg::ELEM_COUNT],
    output int                       tests_passed,
    output int                       tests_failed,
    output int                       err_total
);

    localparam int D = mxu_cfg_pkg::ARRAY_DIM;
    localparam int E = mxu_cfg_pkg::ELEM_COUNT;

    mxu_cfg_pkg::elem_t expected [E];
    logic open_q     = 1'b0;
    int   n_pass     = 0;
    int   n_fail     = 0;
    int   n_err      = 0;
    int   wr_count   = 0;
    int   done_count = 0;
    int   test_errs  = 0;

    assign tests_passed = n_pass;
    assign tests_failed = n_fail;
    assign err_total    = n_err;

    // O[r][c] = sum over k of X[r][k] * W[k][c], kept to 32 bits
    function automatic mxu_cfg_pkg::elem_t ref_elem(
        input mxu_cfg_pkg::elem_t w [E],
        input mxu_cfg_pkg::elem_t x [E],
        input int r,
        input int c
    );
        mxu_cfg_pkg::elem_t acc;
        acc = '0;
        for (int k = 0; k < D; k++) begin
            acc = acc + x[r * D + k] * w[k * D + c];
        end
        return acc;
    endfunction

    //////////////////////////////////////////////////
    // Bus watch, sampled mid-cycle
    //////////////////////////////////////////////////

    always @(negedge clk) begin
        mxu_mem_pkg::addr_t exp_addr;
        if (test_open && !open_q) begin
            for (int i = 0; i < E; i++) begin
                expected[i] = ref_elem(w_mat, x_mat, i / D, i % D);
            end
            wr_count   = 0;
            done_count = 0;
            test_errs  = 0;
        end
        if (test_open) begin
            if (mem_write_en) begin
                exp_addr = exp_base + mxu_mem_pkg::addr_t'(wr_count);
                if (quiet || wr_count >= E) begin
                    $display("test %0s wrote unexpectedly to address 0x%0h",
                             test_name, mem_req_addr);
                    test_errs++;
                end else begin
                    if (mem_req_addr !== exp_addr) begin
                        $display("[FAIL] %0s address of word %0d expected 0x%0h actual 0x%0h",
                                 test_name, wr_count, exp_addr, mem_req_addr);
                        test_errs++;
                    end
                    if (mem_req_data !== expected[wr_count]) begin
                        $display("[FAIL] %0s O[%0d][%0d] expected %0d actual %0d",
                                 test_name, wr_count / D, wr_count % D,
                                 expected[wr_count], mem_req_data);
                        test_errs++;
                    end
                end
                wr_count++;
            end
            if (done) begin
                done_count++;
            end
            if (quiet && mem_read_en) begin
                $display("test %0s saw a memory read with no run started", test_name);
                test_errs++;
            end
        end else if (rst_n && (mem_write_en || done)) begin
            $display("a write or done strobe appeared while no test was running");
            n_err++;
        end
        if (!test_open && open_q) begin
            if (!quiet && wr_count != E) begin
                $display("[FAIL] %0s write count expected %0d actual %0d",
                         test_name, E, wr_count);
                test_errs++;
            end
            if (done_count != (quiet ? 0 : 1)) begin
                $display("[FAIL] %0s done pulses expected %0d actual %0d",
                         test_name, quiet ? 0 : 1, done_count);
                test_errs++;
            end
            if (test_errs == 0) begin
                n_pass++;
                $display("test %0s passed", test_name);
            end else begin
                n_fail++;
                $display("test %0s failed with %0d errors", test_name, test_errs);
            end
            n_err += test_errs;
        end
        open_q = test_open;
    end

endmodule

`default_nettype wire

//--- sources.f
logic/mxu_cfg_pkg.sv
logic/mxu_mem_pkg.sv
logic/mxu_pe.sv
logic/mxu_array.sv
logic/mxu_feeder.sv
logic/mxu_result_collect.sv
logic/mxu_ctrl.sv
logic/mxu_top.sv
sim/tb_clk_gen.sv
sim/tb_mxu_checker.sv
sim/mxu_props.sv
sim/tb_mxu.sv
